//--- src/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Datapath and instruction word width
`define EXEC_DATA_W 16

// Instructions issued together in one bundle
// 1, 2 and 4 are the supported lane counts
`define EXEC_NUM_LANES 2

// Cycles from a sampled in_valid to out_valid
// Decode, execute and retire each add one register stage
`define EXEC_LATENCY 3

// Byte distance between consecutive instructions
`define EXEC_INSTR_BYTES 2

`endif

//--- src/exec_pkg.sv
`default_nettype none

package exec_pkg;

  // Major opcode, instruction bits 15..11
  // Memory, LBI and linking jumps are not handled by this cluster
  typedef enum logic [4:0] {
    OP_HALT  = 5'b00000,
    OP_NOP   = 5'b00001,
    OP_J     = 5'b00100,
    OP_JR    = 5'b00101,
    OP_ADDI  = 5'b01000,
    OP_SUBI  = 5'b01001,
    OP_XORI  = 5'b01010,
    OP_ANDNI = 5'b01011,
    OP_BEQZ  = 5'b01100,
    OP_BNEZ  = 5'b01101,
    OP_BLTZ  = 5'b01110,
    OP_BGEZ  = 5'b01111,
    OP_SLBI  = 5'b10010,
    OP_ROLI  = 5'b10100,
    OP_SLLI  = 5'b10101,
    OP_RORI  = 5'b10110,
    OP_SRLI  = 5'b10111,
    OP_BTR   = 5'b11001,
    OP_SHIFT = 5'b11010,
    OP_ARITH = 5'b11011,
    OP_SEQ   = 5'b11100,
    OP_SLT   = 5'b11101,
    OP_SLE   = 5'b11110,
    OP_SCO   = 5'b11111
  } exec_op_e;

  // Low two bits follow the func field / opcode bits 12..11
  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN,
    ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL
  } alu_fn_e;

  typedef enum logic [1:0] {B_REG, B_IMM, B_ZERO} b_sel_e;

  typedef enum logic [1:0] {RES_ALU, RES_SLBI, RES_BTR, RES_COND} res_sel_e;

  // Set conditions, taken straight from opcode bits 12..11
  typedef enum logic [1:0] {CND_EQ, CND_LT, CND_LE, CND_CO} cond_e;

  // Same codes read as branch conditions on the register operand
  localparam cond_e CND_EQZ = CND_EQ;
  localparam cond_e CND_NEZ = CND_LT;
  localparam cond_e CND_LTZ = CND_LE;
  localparam cond_e CND_GEZ = CND_CO;

  typedef enum logic [1:0] {BR_NONE, BR_COND, BR_DISP, BR_REG} br_kind_e;

endpackage

`default_nettype wire

//--- src/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module instr_decoder import exec_pkg::*; #(
  parameter int NUM_LANES = `EXEC_NUM_LANES,
  parameter int DATA_W    = `EXEC_DATA_W
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          in_valid,
  input  wire  [DATA_W-1:0]            pc,
  input  wire  [NUM_LANES*DATA_W-1:0]  instr_bus,
  input  wire  [NUM_LANES*DATA_W-1:0]  data1_bus,
  input  wire  [NUM_LANES*DATA_W-1:0]  data2_bus,
  output logic [NUM_LANES-1:0]         lane_valid,
  output logic [NUM_LANES*DATA_W-1:0]  lane_pc,
  output alu_fn_e  [NUM_LANES-1:0]     alu_fn,
  output b_sel_e   [NUM_LANES-1:0]     b_sel,
  output res_sel_e [NUM_LANES-1:0]     res_sel,
  output cond_e    [NUM_LANES-1:0]     cond_sel,
  output br_kind_e [NUM_LANES-1:0]     br_kind,
  output logic [NUM_LANES*DATA_W-1:0]  imm_b,
  output logic [NUM_LANES*DATA_W-1:0]  imm_br,
  output logic [NUM_LANES*DATA_W-1:0]  op_a,
  output logic [NUM_LANES*DATA_W-1:0]  op_b,
  output logic [NUM_LANES-1:0]         wr_en,
  output logic [NUM_LANES-1:0]         is_halt
);

  logic [NUM_LANES*DATA_W-1:0] lane_pc_d;
  logic [NUM_LANES*DATA_W-1:0] imm_b_d;
  logic [NUM_LANES*DATA_W-1:0] imm_br_d;
  alu_fn_e  [NUM_LANES-1:0]    alu_fn_d;
  b_sel_e   [NUM_LANES-1:0]    b_sel_d;
  res_sel_e [NUM_LANES-1:0]    res_sel_d;
  cond_e    [NUM_LANES-1:0]    cond_sel_d;
  br_kind_e [NUM_LANES-1:0]    br_kind_d;
  logic [NUM_LANES-1:0]        wr_en_d;
  logic [NUM_LANES-1:0]        is_halt_d;

  always_comb begin
    logic [DATA_W-1:0] instr;
    exec_op_e          op;
    logic [DATA_W-1:0] imm5_s, imm5_z, imm8_s, imm8_z, imm11_s;
    for (int i = 0; i < NUM_LANES; i++) begin
      instr   = instr_bus[i*DATA_W +: DATA_W];
      op      = exec_op_e'(instr[15:11]);
      imm5_s  = {{(DATA_W-5){instr[4]}}, instr[4:0]};
      imm5_z  = {{(DATA_W-5){1'b0}}, instr[4:0]};
      imm8_s  = {{(DATA_W-8){instr[7]}}, instr[7:0]};
      imm8_z  = {{(DATA_W-8){1'b0}}, instr[7:0]};
      imm11_s = {{(DATA_W-11){instr[10]}}, instr[10:0]};

      lane_pc_d[i*DATA_W +: DATA_W] = pc + DATA_W'(i * `EXEC_INSTR_BYTES);

      // Anything unrecognised falls through as a non-writing no-op
      alu_fn_d[i]   = ALU_ADD;
      b_sel_d[i]    = B_ZERO;
      res_sel_d[i]  = RES_ALU;
      cond_sel_d[i] = cond_e'(instr[12:11]);
      br_kind_d[i]  = BR_NONE;
      wr_en_d[i]    = 1'b0;
      is_halt_d[i]  = 1'b0;
      imm_b_d[i*DATA_W +: DATA_W]  = imm5_s;
      imm_br_d[i*DATA_W +: DATA_W] = imm8_s;

      case (op)
        OP_HALT: is_halt_d[i] = 1'b1;
        OP_NOP:  wr_en_d[i] = 1'b0;
        OP_ADDI, OP_SUBI: begin
          alu_fn_d[i] = alu_fn_e'({1'b0, instr[12:11]});
          b_sel_d[i]  = B_IMM;
          wr_en_d[i]  = 1'b1;
        end
        // Logical immediates are zero extended
        OP_XORI, OP_ANDNI: begin
          alu_fn_d[i] = alu_fn_e'({1'b0, instr[12:11]});
          b_sel_d[i]  = B_IMM;
          imm_b_d[i*DATA_W +: DATA_W] = imm5_z;
          wr_en_d[i]  = 1'b1;
        end
        OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
          alu_fn_d[i] = alu_fn_e'({1'b1, instr[12:11]});
          b_sel_d[i]  = B_IMM;
          wr_en_d[i]  = 1'b1;
        end
        OP_ARITH, OP_SHIFT: begin
          alu_fn_d[i] = alu_fn_e'({~instr[11], instr[1:0]});
          b_sel_d[i]  = B_REG;
          wr_en_d[i]  = 1'b1;
        end
        OP_SLBI: begin
          res_sel_d[i] = RES_SLBI;
          imm_b_d[i*DATA_W +: DATA_W] = imm8_z;
          wr_en_d[i]   = 1'b1;
        end
        OP_BTR: begin
          res_sel_d[i] = RES_BTR;
          wr_en_d[i]   = 1'b1;
        end
        // Carry test needs the sum, the others the difference
        OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
          alu_fn_d[i]  = (op == OP_SCO) ? ALU_ADD : ALU_SUB;
          b_sel_d[i]   = B_REG;
          res_sel_d[i] = RES_COND;
          wr_en_d[i]   = 1'b1;
        end
        OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: br_kind_d[i] = BR_COND;
        OP_J: begin
          br_kind_d[i] = BR_DISP;
          imm_br_d[i*DATA_W +: DATA_W] = imm11_s;
        end
        OP_JR: br_kind_d[i] = BR_REG;
        default: wr_en_d[i] = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lane_valid <= '0;
      wr_en      <= '0;
      is_halt    <= '0;
    end else begin
      lane_valid <= {NUM_LANES{in_valid}};
      wr_en      <= wr_en_d;
      is_halt    <= is_halt_d;
    end
  end

  // Payload and steering levels
  always_ff @(posedge clk) begin
    lane_pc  <= lane_pc_d;
    alu_fn   <= alu_fn_d;
    b_sel    <= b_sel_d;
    res_sel  <= res_sel_d;
    cond_sel <= cond_sel_d;
    br_kind  <= br_kind_d;
    imm_b    <= imm_b_d;
    imm_br   <= imm_br_d;
    op_a     <= data1_bus;
    op_b     <= data2_bus;
  end

endmodule

`default_nettype wire

//--- src/exec_lane.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module exec_lane import exec_pkg::*; #(
  parameter int DATA_W = `EXEC_DATA_W
) (
  input  wire                clk,
  input  wire                rst,
  input  wire                lane_valid,
  input  wire  [DATA_W-1:0]  lane_pc,
  input  wire  alu_fn_e      alu_fn,
  input  wire  b_sel_e       b_sel,
  input  wire  res_sel_e     res_sel,
  input  wire  cond_e        cond_sel,
  input  wire  br_kind_e     br_kind,
  input  wire  [DATA_W-1:0]  imm_b,
  input  wire  [DATA_W-1:0]  imm_br,
  input  wire  [DATA_W-1:0]  op_a,
  input  wire  [DATA_W-1:0]  op_b,
  input  wire                wr_en,
  input  wire                is_halt,
  output logic               res_valid,
  output logic [DATA_W-1:0]  result,
  output logic               res_wr,
  output logic               redirect,
  output logic [DATA_W-1:0]  target,
  output logic               res_halt,
  output logic [DATA_W-1:0]  res_pc
);

  localparam int SH_W = $clog2(DATA_W);

  logic [DATA_W-1:0] b_opnd;
  logic [DATA_W-1:0] b_eff;
  logic [DATA_W-1:0] alu_sum;
  logic [DATA_W-1:0] alu_out;
  logic [DATA_W-1:0] slbi_out;
  logic [DATA_W-1:0] btr_out;
  logic [DATA_W-1:0] cond_out;
  logic [DATA_W-1:0] res_mux;
  logic [DATA_W-1:0] br_base;
  logic [DATA_W-1:0] br_target;
  logic [SH_W-1:0]   sh_amt;
  logic              is_sub;
  logic              carry_out;
  logic              flag_z, flag_n, flag_v;
  logic              set_bit;
  logic              br_taken;
  logic              take_flow;

  always_comb begin
    case (b_sel)
      B_REG:   b_opnd = op_b;
      B_IMM:   b_opnd = imm_b;
      B_ZERO:  b_opnd = '0;
      default: b_opnd = '0;
    endcase
  end

  // Subtract as A + ~B + 1
  assign is_sub = (alu_fn == ALU_SUB);
  assign b_eff  = is_sub ? ~b_opnd : b_opnd;
  assign {carry_out, alu_sum} = {1'b0, op_a} + {1'b0, b_eff} + (DATA_W+1)'(is_sub);

  assign flag_z = (alu_sum == '0);
  assign flag_n = alu_sum[DATA_W-1];
  // Signed overflow when both addends agree in sign and the sum does not
  assign flag_v = (op_a[DATA_W-1] == b_eff[DATA_W-1]) &&
                  (alu_sum[DATA_W-1] != op_a[DATA_W-1]);

  assign sh_amt = b_opnd[SH_W-1:0];

  always_comb begin
    case (alu_fn)
      ALU_ADD, ALU_SUB: alu_out = alu_sum;
      ALU_XOR:          alu_out = op_a ^ b_opnd;
      ALU_ANDN:         alu_out = op_a & ~b_opnd;
      ALU_ROL:          alu_out = (op_a << sh_amt) | (op_a >> (DATA_W - sh_amt));
      ALU_SLL:          alu_out = op_a << sh_amt;
      ALU_ROR:          alu_out = (op_a >> sh_amt) | (op_a << (DATA_W - sh_amt));
      ALU_SRL:          alu_out = op_a >> sh_amt;
      default:          alu_out = alu_sum;
    endcase
  end

  // imm_b holds the zero extended byte here
  assign slbi_out = (op_a << 8) | imm_b;

  always_comb begin
    for (int i = 0; i < DATA_W; i++) begin
      btr_out[i] = op_a[DATA_W-1-i];
    end
  end

  // Signed compare uses N xor V so overflow does not flip the answer
  always_comb begin
    set_bit = 1'b0;
    case (cond_sel)
      CND_EQ: set_bit = flag_z;
      CND_LT: set_bit = flag_n ^ flag_v;
      CND_LE: set_bit = flag_z | (flag_n ^ flag_v);
      CND_CO: set_bit = carry_out;
      default: set_bit = 1'b0;
    endcase
  end

  assign cond_out = {{(DATA_W-1){1'b0}}, set_bit};

  always_comb begin
    case (res_sel)
      RES_ALU:  res_mux = alu_out;
      RES_SLBI: res_mux = slbi_out;
      RES_BTR:  res_mux = btr_out;
      RES_COND: res_mux = cond_out;
      default:  res_mux = alu_out;
    endcase
  end

  // Branch test on the register value itself
  always_comb begin
    br_taken = 1'b0;
    case (cond_sel)
      CND_EQZ: br_taken = (op_a == '0);
      CND_NEZ: br_taken = (op_a != '0);
      CND_LTZ: br_taken = op_a[DATA_W-1];
      CND_GEZ: br_taken = ~op_a[DATA_W-1];
      default: br_taken = 1'b0;
    endcase
  end

  // JR adds to the register, everything else to PC + 2
  assign br_base   = (br_kind == BR_REG) ? op_a : lane_pc + DATA_W'(`EXEC_INSTR_BYTES);
  assign br_target = br_base + imm_br;
  assign take_flow = ((br_kind == BR_COND) && br_taken) ||
                     (br_kind == BR_DISP) || (br_kind == BR_REG);

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      res_wr    <= 1'b0;
      redirect  <= 1'b0;
      res_halt  <= 1'b0;
    end else begin
      res_valid <= lane_valid;
      res_wr    <= lane_valid & wr_en;
      redirect  <= lane_valid & take_flow;
      res_halt  <= lane_valid & is_halt;
    end
  end

  always_ff @(posedge clk) begin
    result <= res_mux;
    target <= br_target;
    res_pc <= lane_pc;
  end

endmodule

`default_nettype wire

//--- src/bundle_retire.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module bundle_retire #(
  parameter int NUM_LANES = `EXEC_NUM_LANES,
  parameter int DATA_W    = `EXEC_DATA_W
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire  [NUM_LANES-1:0]         res_valid,
  input  wire  [NUM_LANES*DATA_W-1:0]  result,
  input  wire  [NUM_LANES-1:0]         res_wr,
  input  wire  [NUM_LANES-1:0]         redirect,
  input  wire  [NUM_LANES*DATA_W-1:0]  target,
  input  wire  [NUM_LANES-1:0]         res_halt,
  input  wire  [NUM_LANES*DATA_W-1:0]  res_pc,
  output logic                         out_valid,
  output logic [NUM_LANES-1:0]         wb_en,
  output logic [NUM_LANES*DATA_W-1:0]  wb_data,
  output logic [DATA_W-1:0]            next_pc,
  output logic                         halted
);

  logic [NUM_LANES-1:0] wb_en_d;
  logic [DATA_W-1:0]    next_pc_d;
  logic                 halted_d;

  // Walk up from lane 0 and stop at the first lane that leaves the bundle
  always_comb begin
    logic stop;
    stop      = 1'b0;
    wb_en_d   = '0;
    halted_d  = 1'b0;
    next_pc_d = res_pc[0 +: DATA_W] + DATA_W'(NUM_LANES * `EXEC_INSTR_BYTES);
    for (int i = 0; i < NUM_LANES; i++) begin
      if (!stop) begin
        wb_en_d[i] = res_valid[i] & res_wr[i];
        if (redirect[i]) begin
          next_pc_d = target[i*DATA_W +: DATA_W];
          stop      = 1'b1;
        end else if (res_halt[i]) begin
          // Halt parks the PC on itself
          next_pc_d = res_pc[i*DATA_W +: DATA_W];
          halted_d  = 1'b1;
          stop      = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      wb_en     <= '0;
      halted    <= 1'b0;
    end else begin
      out_valid <= res_valid[0];
      wb_en     <= wb_en_d;
      halted    <= halted_d;
    end
  end

  always_ff @(posedge clk) begin
    wb_data <= result;
    next_pc <= next_pc_d;
  end

endmodule

`default_nettype wire

//--- src/exec_cluster.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module exec_cluster import exec_pkg::*; (
  input  wire                                       clk,
  input  wire                                       rst,
  input  wire                                       in_valid,
  input  wire  [`EXEC_DATA_W-1:0]                   pc,
  input  wire  [`EXEC_NUM_LANES*`EXEC_DATA_W-1:0]   instr_bus,
  input  wire  [`EXEC_NUM_LANES*`EXEC_DATA_W-1:0]   data1_bus,
  input  wire  [`EXEC_NUM_LANES*`EXEC_DATA_W-1:0]   data2_bus,
  output wire                                       out_valid,
  output wire  [`EXEC_NUM_LANES-1:0]                wb_en,
  output wire  [`EXEC_NUM_LANES*`EXEC_DATA_W-1:0]   wb_data,
  output wire  [`EXEC_DATA_W-1:0]                   next_pc,
  output wire                                       halted
);

  localparam int N = `EXEC_NUM_LANES;
  localparam int W = `EXEC_DATA_W;

  // Decode to execute
  logic [N-1:0]     lane_valid;
  logic [N*W-1:0]   lane_pc;
  alu_fn_e  [N-1:0] alu_fn;
  b_sel_e   [N-1:0] b_sel;
  res_sel_e [N-1:0] res_sel;
  cond_e    [N-1:0] cond_sel;
  br_kind_e [N-1:0] br_kind;
  logic [N*W-1:0]   imm_b, imm_br, op_a, op_b;
  logic [N-1:0]     wr_en, is_halt;

  // Execute to retire
  logic [N-1:0]     res_valid, res_wr, redirect, res_halt;
  logic [N*W-1:0]   result, target, res_pc;

  instr_decoder #(.NUM_LANES(N), .DATA_W(W)) instr_decoder_inst (
    .clk(clk), .rst(rst), .in_valid(in_valid), .pc(pc),
    .instr_bus(instr_bus), .data1_bus(data1_bus), .data2_bus(data2_bus),
    .lane_valid(lane_valid), .lane_pc(lane_pc), .alu_fn(alu_fn), .b_sel(b_sel),
    .res_sel(res_sel), .cond_sel(cond_sel), .br_kind(br_kind),
    .imm_b(imm_b), .imm_br(imm_br), .op_a(op_a), .op_b(op_b),
    .wr_en(wr_en), .is_halt(is_halt)
  );

  for (genvar i = 0; i < N; i++) begin : g_lane
    exec_lane #(.DATA_W(W)) exec_lane_inst (
      .clk(clk), .rst(rst),
      .lane_valid(lane_valid[i]), .lane_pc(lane_pc[i*W +: W]),
      .alu_fn(alu_fn[i]), .b_sel(b_sel[i]), .res_sel(res_sel[i]),
      .cond_sel(cond_sel[i]), .br_kind(br_kind[i]),
      .imm_b(imm_b[i*W +: W]), .imm_br(imm_br[i*W +: W]),
      .op_a(op_a[i*W +: W]), .op_b(op_b[i*W +: W]),
      .wr_en(wr_en[i]), .is_halt(is_halt[i]),
      .res_valid(res_valid[i]), .result(result[i*W +: W]), .res_wr(res_wr[i]),
      .redirect(redirect[i]), .target(target[i*W +: W]),
      .res_halt(res_halt[i]), .res_pc(res_pc[i*W +: W])
    );
  end

  bundle_retire #(.NUM_LANES(N), .DATA_W(W)) bundle_retire_inst (
    .clk(clk), .rst(rst),
    .res_valid(res_valid), .result(result), .res_wr(res_wr),
    .redirect(redirect), .target(target), .res_halt(res_halt), .res_pc(res_pc),
    .out_valid(out_valid), .wb_en(wb_en), .wb_data(wb_data),
    .next_pc(next_pc), .halted(halted)
  );

endmodule

`default_nettype wire

//--- verif/exec_cluster_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module exec_cluster_tb;

  localparam int N          = `EXEC_NUM_LANES;
  localparam int W          = `EXEC_DATA_W;
  localparam int NUM_VEC    = 21;
  localparam int FIELDS     = 5 + 4 * N;
  localparam int RST_CYCLES = 8;
  // Reset, every vector, pipeline drain and some slack
  localparam int MAX_CYCLES = RST_CYCLES + NUM_VEC + `EXEC_LATENCY + 20;

  // Column offsets within one vector line
  localparam int F_VALID = 0;
  localparam int F_PC    = 1;
  localparam int F_LANE  = 2;
  localparam int F_WB_EN = 2 + 3 * N;
  localparam int F_WB_D  = 3 + 3 * N;
  localparam int F_NPC   = 3 + 4 * N;
  localparam int F_HALT  = 4 + 4 * N;

  logic           clk;
  logic           rst;
  logic           in_valid;
  logic [W-1:0]   pc;
  logic [N*W-1:0] instr_bus;
  logic [N*W-1:0] data1_bus;
  logic [N*W-1:0] data2_bus;
  wire            out_valid;
  wire  [N-1:0]   wb_en;
  wire  [N*W-1:0] wb_data;
  wire  [W-1:0]   next_pc;
  wire            halted;

  logic [W-1:0] vec_mem [0:NUM_VEC*FIELDS-1];
  int           pend_vec_q[$];
  int           pend_due_q[$];
  int           cycle;

  exec_cluster exec_cluster_inst (
    .clk(clk), .rst(rst), .in_valid(in_valid), .pc(pc),
    .instr_bus(instr_bus), .data1_bus(data1_bus), .data2_bus(data2_bus),
    .out_valid(out_valid), .wb_en(wb_en), .wb_data(wb_data),
    .next_pc(next_pc), .halted(halted)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic compare_word(input string name, input logic [W-1:0] exp,
                              input logic [W-1:0] act);
    assert (act === exp) else
      stop_with_error($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                                $time, name, exp, act));
  endtask

  always @(posedge clk) begin
    if (cycle >= MAX_CYCLES) begin
      stop_with_error($sformatf("Timeout after %0d cycles with %0d bundles pending",
                                cycle, pend_vec_q.size()));
    end
  end

  // Results are sampled on the falling edge, half a cycle after they settle
  always @(negedge clk) begin
    int           v;
    int           due;
    int           base;
    logic [N-1:0] exp_en;
    if (rst) begin
      if (cycle > 0) begin
        assert (out_valid === 1'b0) else stop_with_error("out_valid is high during reset");
      end
    end else begin
      assert (!$isunknown(out_valid)) else stop_with_error("out_valid is unknown after reset");
      if (out_valid) begin
        assert (pend_vec_q.size() != 0) else
          stop_with_error("out_valid seen with no bundle pending");
        v    = pend_vec_q.pop_front();
        due  = pend_due_q.pop_front();
        base = v * FIELDS;
        assert (cycle == due) else
          stop_with_error($sformatf("Bundle %0d came out at cycle %0d instead of cycle %0d",
                                    v, cycle, due));
        exp_en = vec_mem[base + F_WB_EN][N-1:0];
        compare_word("wb_en", W'(exp_en), W'(wb_en));
        // Masked lanes carry no defined write data
        for (int i = 0; i < N; i++) begin
          if (exp_en[i]) begin
            compare_word($sformatf("wb_data[%0d]", i), vec_mem[base + F_WB_D + i],
                         wb_data[i*W +: W]);
          end
        end
        compare_word("next_pc", vec_mem[base + F_NPC], next_pc);
        compare_word("halted", vec_mem[base + F_HALT], W'(halted));
      end else if (pend_due_q.size() != 0) begin
        assert (pend_due_q[0] > cycle) else
          stop_with_error($sformatf("Bundle %0d did not come out at cycle %0d",
                                    pend_vec_q[0], pend_due_q[0]));
      end
    end
  end

  initial begin
    int             v;
    int             base;
    logic [N*W-1:0] instr_v;
    logic [N*W-1:0] d1_v;
    logic [N*W-1:0] d2_v;
    clk       = 1'b0;
    cycle     = 0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    pc        = '0;
    instr_bus = '0;
    data1_bus = '0;
    data2_bus = '0;

    $readmemh("verif/exec_input.txt", vec_mem);
    for (int k = 0; k < NUM_VEC * FIELDS; k++) begin
      assert (!$isunknown(vec_mem[k])) else
        stop_with_error($sformatf("Vector file is short or corrupt at word %0d", k));
    end

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // One bundle per cycle, back to back
    for (v = 0; v < NUM_VEC; v++) begin
      @(posedge clk);
      base = v * FIELDS;
      for (int i = 0; i < N; i++) begin
        instr_v[i*W +: W] = vec_mem[base + F_LANE + 3*i];
        d1_v[i*W +: W]    = vec_mem[base + F_LANE + 3*i + 1];
        d2_v[i*W +: W]    = vec_mem[base + F_LANE + 3*i + 2];
      end
      in_valid  <= vec_mem[base + F_VALID][0];
      pc        <= vec_mem[base + F_PC];
      instr_bus <= instr_v;
      data1_bus <= d1_v;
      data2_bus <= d2_v;
      if (vec_mem[base + F_VALID][0]) begin
        // cycle still holds the count from before this edge
        pend_vec_q.push_back(v);
        pend_due_q.push_back(cycle + 1 + `EXEC_LATENCY);
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;

    // Drain the pipeline and watch for a stray out_valid
    repeat (`EXEC_LATENCY + 2) @(posedge clk);

    if (pend_vec_q.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_with_error("Bundles still pending at end of run");
    end
  end

endmodule

`default_nettype wire

//--- verif/exec_input.txt
// valid pc | lane0 instr data1 data2 | lane1 instr data1 data2 |
// exp wb_en | exp wb_data lane0 lane1 | exp next_pc | exp halted (all hex)
1 0100 4143 1234 0000 495E 0010 0000 3 1237 0012 0104 0
1 0104 515F F0F0 0000 5950 00FF 0000 3 F0EF 00EF 0108 0
1 0108 D94C 7FFF 0001 D94D 0005 0007 3 8000 FFFE 010C 0
1 010C D94E AAAA 0FF0 D94F FFFF 1234 3 A55A EDCB 0110 0
1 0110 A144 1234 0000 A943 8421 0000 3 2341 2108 0114 0
1 0114 B141 0001 0000 B94F 8000 0000 3 8000 0001 0118 0
1 0118 D14C F00F 0008 D14F FFFF 0004 3 0FF0 0FFF 011C 0
1 011C 91A5 0012 0000 C908 1234 0000 3 12A5 2C48 0120 0
1 0120 E14C 5555 5555 E14C 5555 5554 3 0001 0000 0124 0
1 0124 E94C 8000 7FFF E94C 0003 0003 3 0001 0000 0128 0
1 0128 F14C 0003 0003 F14C 7FFF 8000 3 0001 0000 012C 0
1 012C F94C FFFF 0001 F94C FFFE 0001 3 0001 0000 0130 0
1 0130 6110 0000 0000 4143 0001 0000 0 0000 0000 0142 0
1 0200 69F0 0000 0000 4143 0001 0000 2 0000 0004 0204 0
1 0204 71F0 8000 0000 4143 0001 0000 0 0000 0000 01F6 0
1 0300 7904 FFFF 0000 27FC 0000 0000 0 0000 0000 0300 0
1 0400 2040 0000 0000 91A5 0012 0000 0 0000 0000 0442 0
1 0500 29FE 1000 0000 C908 1234 0000 0 0000 0000 0FFE 0
0 0600 4143 0001 0000 4143 0001 0000 0 0000 0000 0000 0
1 0700 4143 0010 0000 0000 0000 0000 1 0013 0000 0702 1
1 0800 0800 1234 5678 1000 1234 5678 0 0000 0000 0804 0

//--- filelist.f
+incdir+src
src/exec_pkg.sv
src/instr_decoder.sv
src/exec_lane.sv
src/bundle_retire.sv
src/exec_cluster.sv
verif/exec_cluster_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module exec_cluster_tb -o exec_cluster_sim -f filelist.f \
  && ./obj_dir/exec_cluster_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^=== PASS ===$" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
